//--- csrUnit.f
+incdir+include
src/privPkg.sv
src/csrPkg.sv
src/csrAccess.sv
src/csrStatus.sv
src/privMode.sv
src/csrUnit.sv
dv/csrUnitTb.sv

//--- dv/csrUnitTb.sv
/*
  CSR unit testbench
  directed tests against a reference model of mstatus, mode and scratch
*/
`timescale 1ns/1ps

module csrUnitTb;

  localparam int XLEN      = 64;
  localparam int clkPeriod = 100;
  localparam int testCount = 6;

  logic clk, reset, stall, csrEn, trap, trapDelegated, mret, sret, wfi, fpWrite;
  privPkg::csrOp_t    csrOp;
  logic [11:0]        csrAddr;
  logic [XLEN-1:0]    csrSrc;
  logic [XLEN-1:0]    readData;
  privPkg::privMode_t privMode, statusMpp;
  logic illegal, statusMie, statusSie, statusTvm, statusMxr, statusSum, statusMprv;

  // reference model state
  logic mTsr, mTw, mTvm, mMxr, mSum, mMprv, mSpp, mMpie, mSpie, mMie, mSie;
  logic [1:0]         mFs;
  privPkg::privMode_t mMpp, mMode;
  logic [XLEN-1:0]    mScratch, sScratch;
  logic [31:0]        lfsr;
  int                 errorCount;

  csrUnit csrUnit_i (.*);

  always #(clkPeriod / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // compare tasks
  task automatic checkWord(input string name, input logic [XLEN-1:0] got, exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkMode(input string name, input privPkg::privMode_t got, exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkBit(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      errorCount++;
    end
  endtask

  //////////////////////////////////////////////////
  // random source in galois form of x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [XLEN-1:0] randWord();
    logic [XLEN-1:0] w;
    w = '0;
    for (int i = 0; i < XLEN; i++) begin
      w    = {w[XLEN-2:0], lfsr[0]};  // one step per bit
      lfsr = lfsrNext(lfsr);
    end
    return w;
  endfunction

  //////////////////////////////////////////////////
  // reference model
  function automatic privPkg::privMode_t legalMpp(input logic [1:0] v);
    case (v)
      2'b00:   return privPkg::userMode;
      2'b01:   return privPkg::superMode;
      default: return privPkg::machineMode;  // 10 is reserved
    endcase
  endfunction

  function automatic logic [XLEN-1:0] mstatusModel();
    logic [XLEN-1:0] w;
    w = '0;
    w[csrPkg::posTsr]  = mTsr;
    w[csrPkg::posTw]   = mTw;
    w[csrPkg::posTvm]  = mTvm;
    w[csrPkg::posMxr]  = mMxr;
    w[csrPkg::posSum]  = mSum;
    w[csrPkg::posMprv] = mMprv;
    w[csrPkg::posFs +: 2]  = mFs;
    w[csrPkg::posMpp +: 2] = mMpp;
    w[csrPkg::posSpp]  = mSpp;
    w[csrPkg::posMpie] = mMpie;
    w[csrPkg::posSpie] = mSpie;
    w[csrPkg::posMie]  = mMie;
    w[csrPkg::posSie]  = mSie;
    w[35:32] = 4'b1010;         // SXL and UXL for 64-bit S and U
    w[63]    = mFs == 2'b11;    // SD
    return w;
  endfunction

  function automatic logic [XLEN-1:0] sstatusModel();
    logic [XLEN-1:0] w;
    w = '0;
    w[csrPkg::posMxr] = mMxr;
    w[csrPkg::posSum] = mSum;
    w[csrPkg::posFs +: 2] = mFs;
    w[csrPkg::posSpp]  = mSpp;
    w[csrPkg::posSpie] = mSpie;
    w[csrPkg::posSie]  = mSie;
    w[33:32] = 2'b10;  // UXL
    w[63]    = mFs == 2'b11;
    return w;
  endfunction

  function automatic logic [XLEN-1:0] modelRead(input logic [11:0] addr);
    if (addr == csrPkg::addrMstatus)  return mstatusModel();
    if (addr == csrPkg::addrSstatus)  return sstatusModel();
    if (addr == csrPkg::addrMscratch) return mScratch;
    if (addr == csrPkg::addrSscratch) return sScratch;
    return '0;  // unknown reads zero
  endfunction

  // needs a known address, enough privilege and a writable address
  function automatic logic csrLegal(input logic [11:0] addr);
    logic known;
    known = addr == csrPkg::addrMstatus || addr == csrPkg::addrSstatus ||
            addr == csrPkg::addrMscratch || addr == csrPkg::addrSscratch;
    return known && !(addr[9:8] > mMode) && addr[11:10] != 2'b11;
  endfunction

  function automatic void mstatusWrite(input logic [XLEN-1:0] v);
    {mTsr, mTw, mTvm, mMxr, mSum, mMprv} = v[22:17];
    mFs   = v[csrPkg::posFs +: 2];
    mMpp  = legalMpp(v[csrPkg::posMpp +: 2]);
    mSpp  = v[csrPkg::posSpp];
    mMpie = v[csrPkg::posMpie];
    mSpie = v[csrPkg::posSpie];
    mMie  = v[csrPkg::posMie];
    mSie  = v[csrPkg::posSie];
  endfunction

  function automatic void sstatusWrite(input logic [XLEN-1:0] v);
    mMxr = v[csrPkg::posMxr];  // supervisor subset only
    mSum = v[csrPkg::posSum];
    mFs  = v[csrPkg::posFs +: 2];
    mSpp  = v[csrPkg::posSpp];
    mSpie = v[csrPkg::posSpie];
    mSie  = v[csrPkg::posSie];
  endfunction

  //////////////////////////////////////////////////
  // drivers start and end 5 ns after a rising edge
  task automatic doCsr(input privPkg::csrOp_t op, input logic [11:0] addr,
                       input logic [XLEN-1:0] src);
    logic [XLEN-1:0] oldVal;
    logic [XLEN-1:0] newVal;
    logic            ok;
    oldVal = modelRead(addr);
    ok     = csrLegal(addr);
    case (op)
      privPkg::opSet:   newVal = oldVal | src;
      privPkg::opClear: newVal = oldVal & ~src;
      default:          newVal = src;
    endcase
    csrEn   = 1'b1;
    csrOp   = op;
    csrAddr = addr;
    csrSrc  = src;
    @(negedge clk);
    checkWord("readData", readData, oldVal);
    checkBit("illegal", illegal, !ok);
    @(posedge clk);
    #5 csrEn = 1'b0;
    if (ok && !stall) begin
      if (addr == csrPkg::addrMstatus)       mstatusWrite(newVal);
      else if (addr == csrPkg::addrSstatus)  sstatusWrite(newVal);
      else if (addr == csrPkg::addrMscratch) mScratch = newVal;
      else                                   sScratch = newVal;
    end
  endtask

  // one cycle of trap / return / wfi / fp strobes
  task automatic doEvent(input logic t, d, mr, sr, w, fp);
    logic inM, expIll;
    inM    = mMode == privPkg::machineMode;
    expIll = (mr && !inM) || (w && !inM && mTw) ||
             (sr && !(inM || (mMode == privPkg::superMode && !mTsr)));
    trap          = t;
    trapDelegated = d;
    mret          = mr;
    sret          = sr;
    wfi           = w;
    fpWrite       = fp;
    @(negedge clk);
    checkBit("illegal", illegal, expIll);
    @(posedge clk);
    #5 {trap, trapDelegated, mret, sret, wfi, fpWrite} = '0;
    if (!stall) begin
      if (fp) mFs = 2'b11;
      if (t && d && !inM) begin  // delegated trap
        mSpie = mSie;
        mSie  = 1'b0;
        mSpp  = mMode[0];
        mMode = privPkg::superMode;
      end else if (t) begin
        mMpie = mMie;
        mMie  = 1'b0;
        mMpp  = mMode;
        mMode = privPkg::machineMode;
      end else if (mr && !expIll) begin
        mMie  = mMpie;
        mMpie = 1'b1;
        mMode = mMpp;
        mMpp  = privPkg::userMode;
        mMprv = 1'b0;
      end else if (sr && !expIll) begin
        mSie  = mSpie;
        mSpie = 1'b1;
        mMode = mSpp ? privPkg::superMode : privPkg::userMode;
        mSpp  = 1'b0;
        mMprv = 1'b0;
      end
    end
  endtask

  // look at a CSR without an access strobe
  task automatic peekCsr(input string name, input logic [11:0] addr);
    csrEn   = 1'b0;
    csrAddr = addr;
    @(negedge clk);
    checkWord(name, readData, modelRead(addr));
    checkBit("illegal", illegal, 1'b0);
    checkMode("privMode", privMode, mMode);
    checkMode("statusMpp", statusMpp, mMpp);
    checkBit("statusMie", statusMie, mMie);
    checkBit("statusSie", statusSie, mSie);
    checkBit("statusMprv", statusMprv, mMprv);
    checkBit("statusTvm", statusTvm, mTvm);
    checkBit("statusMxr", statusMxr, mMxr);
    checkBit("statusSum", statusSum, mSum);
    @(posedge clk);
    #5;
  endtask

  task automatic checkState();
    peekCsr("mstatus", csrPkg::addrMstatus);
    peekCsr("sstatus", csrPkg::addrSstatus);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  task automatic testReset();
    checkState();
  endtask

  task automatic testMstatusWrites();
    for (int i = 0; i < 8; i++) begin
      doCsr(privPkg::opWrite, csrPkg::addrMstatus, randWord());
      checkState();
    end
    doCsr(privPkg::opWrite, csrPkg::addrMstatus, 64'h1000);  // MPP = 10
    checkState();
    doCsr(privPkg::opSet, csrPkg::addrMstatus, randWord());
    checkState();
    doCsr(privPkg::opClear, csrPkg::addrMstatus, randWord());
    checkState();
  endtask

  task automatic testSstatusView();
    for (int i = 0; i < 4; i++) begin
      doCsr(privPkg::opWrite, csrPkg::addrSstatus, randWord());
      checkState();  // mstatus bits outside the mask must hold
    end
    doCsr(privPkg::opWrite, csrPkg::addrMscratch, randWord());
    doCsr(privPkg::opWrite, csrPkg::addrSscratch, randWord());
    peekCsr("mscratch", csrPkg::addrMscratch);
    peekCsr("sscratch", csrPkg::addrSscratch);
  endtask

  task automatic testTrapReturn();
    doCsr(privPkg::opWrite, csrPkg::addrMstatus, 64'h2_0082);  // MPIE SIE MPRV and MPP user
    doEvent(0, 0, 1, 0, 0, 0);  // mret to user clears MPRV
    checkState();
    doEvent(1, 0, 0, 0, 0, 0);  // user to machine
    checkState();
    doEvent(0, 0, 1, 0, 0, 0);
    checkState();
    doEvent(1, 1, 0, 0, 0, 0);  // delegated trap from user to supervisor
    checkState();
    doEvent(0, 0, 0, 1, 0, 0);  // sret back to user
    checkState();
  endtask

  task automatic testLegality();
    doCsr(privPkg::opWrite, csrPkg::addrMstatus, randWord());  // from user
    checkState();
    doEvent(0, 0, 1, 0, 0, 0);  // mret below machine
    doEvent(1, 0, 0, 0, 0, 0);
    doCsr(privPkg::opWrite, csrPkg::addrMstatus, 64'h0060_0800);  // TSR TW and MPP super
    doEvent(0, 0, 1, 0, 0, 0);
    checkState();
    doEvent(0, 0, 0, 1, 0, 0);  // sret with TSR
    doEvent(0, 0, 0, 0, 1, 0);  // wfi with TW
    doEvent(1, 0, 0, 0, 0, 0);
    doCsr(privPkg::opWrite, 12'hF11, randWord());  // read-only space
    doCsr(privPkg::opWrite, csrPkg::addrMstatus, '0);
    stall = 1'b1;
    doCsr(privPkg::opWrite, csrPkg::addrMstatus, randWord());
    doEvent(0, 0, 0, 0, 0, 1);
    stall = 1'b0;
    checkState();
  endtask

  task automatic testFpDirty();
    doCsr(privPkg::opWrite, csrPkg::addrMstatus, 64'h1 << csrPkg::posFs);  // FS initial
    checkState();
    doEvent(0, 0, 0, 0, 0, 1);
    checkState();  // FS and SD both set
  endtask

  //////////////////////////////////////////////////
  initial begin
    clk     = 1'b0;
    reset   = 1'b1;
    stall   = 1'b0;
    csrEn   = 1'b0;
    csrOp   = privPkg::opWrite;
    csrAddr = '0;
    csrSrc  = '0;
    {trap, trapDelegated, mret, sret, wfi, fpWrite} = '0;
    {mTsr, mTw, mTvm, mMxr, mSum, mMprv, mSpp, mMpie, mSpie, mMie, mSie} = '0;
    mFs      = 2'b00;
    mMpp     = privPkg::userMode;
    mMode    = privPkg::machineMode;
    mScratch = '0;
    sScratch = '0;
    lfsr       = 32'had00;
    errorCount = 0;
    repeat (5) @(posedge clk);
    #5 reset = 1'b0;
    testReset();
    testMstatusWrites();
    testSstatusView();
    testTrapReturn();
    testLegality();
    testFpDirty();
    $display("errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog allows 200 cycles per test
  initial begin
    #(testCount * 200 * clkPeriod);
    $display("watchdog expired, the tests did not finish in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- include/csrDefaults.svh
/*
  CSR unit build defaults
  the top level takes its parameter defaults from these macros
*/
`ifndef CSR_DEFAULTS_SVH
`define CSR_DEFAULTS_SVH

`define CSR_XLEN        64   // register width, 32 or 64
`define CSR_SUPPORTED_S 1    // supervisor mode present
`define CSR_SUPPORTED_U 1    // user mode present
`define CSR_SUPPORTED_F 1    // floating point present, enables FS tracking

`endif

//--- run.sh
#!/bin/sh
# build the CSR unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f csrUnit.f \
  --top-module csrUnitTb -o csrUnitSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/csrUnitSim)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

//--- src/csrAccess.sv
/*
  CSR access decode
  address decode, privilege check, write-value forming,
  scratch registers and the read mux
*/
`timescale 1ns/1ps

module csrAccess #(
  parameter int XLEN        = 64,
  parameter int SUPPORTED_S = 1
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,
  input  logic               csrEn,
  input  privPkg::csrOp_t    csrOp,
  input  logic [11:0]        csrAddr,
  input  logic [XLEN-1:0]    csrSrc,
  input  privPkg::privMode_t curMode,
  input  logic [XLEN-1:0]    mstatusWord,
  input  logic [XLEN-1:0]    sstatusWord,
  output logic               writeMstatus,
  output logic               writeSstatus,
  output logic [XLEN-1:0]    csrWriteVal,
  output logic [XLEN-1:0]    readData,
  output logic               accessIllegal
);

  logic [XLEN-1:0] mscratchReg;
  logic [XLEN-1:0] sscratchReg;
  logic            isMstatus;
  logic            isSstatus;
  logic            isMscratch;
  logic            isSscratch;
  logic            known;
  logic            privLow;
  logic            readOnly;
  logic            legal;

  //////////////////////////////////////////////////
  // address decode, supervisor CSRs vanish without S
  assign isMstatus  = csrAddr == csrPkg::addrMstatus;
  assign isSstatus  = (SUPPORTED_S != 0) && (csrAddr == csrPkg::addrSstatus);
  assign isMscratch = csrAddr == csrPkg::addrMscratch;
  assign isSscratch = (SUPPORTED_S != 0) && (csrAddr == csrPkg::addrSscratch);
  assign known      = isMstatus | isSstatus | isMscratch | isSscratch;

  assign privLow  = csrAddr[9:8] > curMode;   // address needs a higher mode
  assign readOnly = csrAddr[11:10] == 2'b11;  // every op here writes
  assign accessIllegal = csrEn & (~known | privLow | readOnly);
  assign legal         = csrEn & ~accessIllegal;

  assign writeMstatus = legal & isMstatus;
  assign writeSstatus = legal & isSstatus;

  // old value, also the base for set / clear
  always_comb begin
    if (isMstatus)       readData = mstatusWord;
    else if (isSstatus)  readData = sstatusWord;
    else if (isMscratch) readData = mscratchReg;
    else if (isSscratch) readData = sscratchReg;
    else                 readData = '0;  // unknown address
  end

  always_comb begin
    case (csrOp)
      privPkg::opSet:   csrWriteVal = readData | csrSrc;
      privPkg::opClear: csrWriteVal = readData & ~csrSrc;
      default:          csrWriteVal = csrSrc;  // plain write
    endcase
  end

  //////////////////////////////////////////////////
  // scratch registers
  always_ff @(posedge clk) begin
    if (reset) begin
      mscratchReg <= '0;
      sscratchReg <= '0;
    end else if (~stall) begin
      if (legal & isMscratch) mscratchReg <= csrWriteVal;
      if (legal & isSscratch) sscratchReg <= csrWriteVal;
    end
  end

endmodule

//--- src/csrPkg.sv
/*
  CSR package
  addresses, mstatus bit positions and the decoded low status word
*/
package csrPkg;

  //////////////////////////////////////////////////
  // addresses handled by this unit
  localparam logic [11:0] addrMstatus  = 12'h300;
  localparam logic [11:0] addrSstatus  = 12'h100;
  localparam logic [11:0] addrMscratch = 12'h340;
  localparam logic [11:0] addrSscratch = 12'h140;

  //////////////////////////////////////////////////
  // mstatus bit positions, low word
  localparam int posTsr  = 22;
  localparam int posTw   = 21;
  localparam int posTvm  = 20;
  localparam int posMxr  = 19;
  localparam int posSum  = 18;
  localparam int posMprv = 17;
  localparam int posFs   = 13;  // two bits
  localparam int posMpp  = 11;  // two bits
  localparam int posSpp  = 8;
  localparam int posMpie = 7;
  localparam int posSpie = 5;
  localparam int posMie  = 3;
  localparam int posSie  = 1;

  localparam int fsWidth  = 2;
  localparam int mppWidth = 2;

  // bits the sstatus view shows and may write, SD and UXL are added on read
  localparam logic [31:0] sstatusMask = (32'h1 << posMxr) | (32'h1 << posSum) |
                                        (32'h3 << posFs)  | (32'h1 << posSpp) |
                                        (32'h1 << posSpie) | (32'h1 << posSie);

  // mstatus fields 22..0, gaps kept as wpri
  typedef struct packed {
    logic [8:0]          wpriHi;   // 31:23, SD lives above the union
    logic                tsr;
    logic                tw;
    logic                tvm;
    logic                mxr;
    logic                sum;
    logic                mprv;
    logic [1:0]          xs;       // no extension state, reads 0
    logic [fsWidth-1:0]  fs;
    logic [mppWidth-1:0] mpp;
    logic [1:0]          wpriMid;  // 10:9
    logic                spp;
    logic                mpie;
    logic                wpri6;
    logic                spie;
    logic                wpri4;    // UPIE not built
    logic                mie;
    logic                wpri2;
    logic                sie;
    logic                wpri0;    // UIE not built
  } statusFields_t;

  typedef union packed {
    logic [31:0]   raw;
    statusFields_t fields;
  } statusLow_u;

endpackage

//--- src/csrStatus.sv
/*
  machine status register
  mstatus with write masks, trap / return stacking, FS dirty tracking,
  and the mstatus and sstatus read views
*/
`timescale 1ns/1ps

module csrStatus #(
  parameter int XLEN        = 64,
  parameter int SUPPORTED_S = 1,
  parameter int SUPPORTED_U = 1,
  parameter int SUPPORTED_F = 1
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,
  input  logic               writeMstatus,
  input  logic               writeSstatus,
  input  logic [XLEN-1:0]    csrWriteVal,
  input  logic               trapTake,
  input  privPkg::privMode_t trapTarget,
  input  privPkg::privMode_t fromMode,
  input  logic               retM,
  input  logic               retS,
  input  logic               fpWrite,
  output logic [XLEN-1:0]    mstatusWord,
  output logic [XLEN-1:0]    sstatusWord,
  output privPkg::privMode_t statusMpp,
  output logic               statusSpp,
  output logic               statusMpie,
  output logic               statusSpie,
  output logic               statusMie,
  output logic               statusSie,
  output logic               statusTsr,
  output logic               statusTw,
  output logic               statusTvm,
  output logic               statusMxr,
  output logic               statusSum,
  output logic               statusMprv
);

  localparam logic hasS = SUPPORTED_S != 0;
  localparam logic hasU = SUPPORTED_U != 0;
  localparam logic hasF = SUPPORTED_F != 0;

  csrPkg::statusLow_u wrWord;  // incoming value, field view
  csrPkg::statusLow_u rdWord;  // low read word, built by field
  privPkg::privMode_t mppNext;
  privPkg::privMode_t mppReg;
  logic               tsrReg;
  logic               twReg;
  logic               tvmReg;
  logic               mxrReg;
  logic               sumReg;
  logic               mprvReg;
  logic [1:0]         fsReg;
  logic [1:0]         fsView;
  logic               sppReg;
  logic               mpieReg;
  logic               spieReg;
  logic               mieReg;
  logic               sieReg;
  logic               sd;

  assign wrWord.raw = csrWriteVal[31:0];

  // MPP only takes modes that exist, anything else lands on machine
  always_comb begin
    case (wrWord.fields.mpp)
      2'b00:   mppNext = hasU ? privPkg::userMode : privPkg::machineMode;
      2'b01:   mppNext = hasS ? privPkg::superMode : privPkg::machineMode;
      default: mppNext = privPkg::machineMode;
    endcase
  end

  //////////////////////////////////////////////////
  // field tie-offs for modes left out of the build
  assign statusTsr  = hasS & tsrReg;
  assign statusTw   = (hasS | hasU) & twReg;  // meaningless with machine only
  assign statusTvm  = hasS & tvmReg;
  assign statusMxr  = hasS & mxrReg;
  assign statusSum  = hasS & sumReg;
  assign statusMprv = hasU & mprvReg;
  assign statusMpp  = mppReg;                 // legal by construction
  assign statusSpp  = hasS & sppReg;
  assign statusMpie = mpieReg;
  assign statusSpie = hasS & spieReg;
  assign statusMie  = mieReg;
  assign statusSie  = hasS & sieReg;
  assign fsView     = hasF ? fsReg : 2'b00;   // off without FP
  assign sd         = fsView == 2'b11;        // XS is always clean

  //////////////////////////////////////////////////
  // status registers
  always_ff @(posedge clk) begin
    if (reset) begin
      tsrReg  <= 1'b0;
      twReg   <= 1'b0;
      tvmReg  <= 1'b0;
      mxrReg  <= 1'b0;
      sumReg  <= 1'b0;
      mprvReg <= 1'b0;
      fsReg   <= 2'b00;
      mppReg  <= privPkg::userMode;
      sppReg  <= 1'b0;
      mpieReg <= 1'b0;
      spieReg <= 1'b0;
      mieReg  <= 1'b0;
      sieReg  <= 1'b0;
    end else if (~stall) begin
      if (fpWrite & hasF) fsReg <= 2'b11;  // any FP state write marks dirty
      if (trapTake) begin
        if (trapTarget == privPkg::machineMode) begin
          mpieReg <= mieReg;   // push machine enable
          mieReg  <= 1'b0;
          mppReg  <= fromMode;
        end else begin
          spieReg <= sieReg;   // delegated, push supervisor enable
          sieReg  <= 1'b0;
          sppReg  <= fromMode[0];
        end
      end else if (retM) begin
        mieReg  <= mpieReg;    // pop
        mpieReg <= 1'b1;
        mppReg  <= hasU ? privPkg::userMode : privPkg::machineMode;
        mprvReg <= 1'b0;
      end else if (retS) begin
        sieReg  <= spieReg;
        spieReg <= hasS;
        sppReg  <= 1'b0;
        mprvReg <= 1'b0;
      end else if (writeMstatus) begin
        tsrReg  <= wrWord.fields.tsr;
        twReg   <= wrWord.fields.tw;
        tvmReg  <= wrWord.fields.tvm;
        mxrReg  <= wrWord.fields.mxr;
        sumReg  <= wrWord.fields.sum;
        mprvReg <= wrWord.fields.mprv;
        fsReg   <= wrWord.fields.fs;
        mppReg  <= mppNext;
        sppReg  <= wrWord.fields.spp;
        mpieReg <= wrWord.fields.mpie;
        spieReg <= wrWord.fields.spie;
        mieReg  <= wrWord.fields.mie;
        sieReg  <= wrWord.fields.sie;
      end else if (writeSstatus) begin
        // supervisor subset only
        mxrReg  <= wrWord.fields.mxr;
        sumReg  <= wrWord.fields.sum;
        fsReg   <= wrWord.fields.fs;
        sppReg  <= wrWord.fields.spp;
        spieReg <= wrWord.fields.spie;
        sieReg  <= wrWord.fields.sie;
      end
    end
  end

  //////////////////////////////////////////////////
  // read views
  always_comb begin
    rdWord             = '0;
    rdWord.fields.tsr  = statusTsr;
    rdWord.fields.tw   = statusTw;
    rdWord.fields.tvm  = statusTvm;
    rdWord.fields.mxr  = statusMxr;
    rdWord.fields.sum  = statusSum;
    rdWord.fields.mprv = statusMprv;
    rdWord.fields.fs   = fsView;
    rdWord.fields.mpp  = statusMpp;
    rdWord.fields.spp  = statusSpp;
    rdWord.fields.mpie = statusMpie;
    rdWord.fields.spie = statusSpie;
    rdWord.fields.mie  = statusMie;
    rdWord.fields.sie  = statusSie;
  end

  generate
    if (XLEN == 64) begin : gView64
      logic [1:0] sxl;
      logic [1:0] uxl;
      assign sxl = hasS ? 2'b10 : 2'b00;  // 64-bit S mode
      assign uxl = hasU ? 2'b10 : 2'b00;  // 64-bit U mode
      assign mstatusWord = {sd, 27'b0, sxl, uxl, rdWord.raw};
      assign sstatusWord = {sd, 29'b0, uxl, rdWord.raw & csrPkg::sstatusMask};
    end else begin : gView32
      assign mstatusWord = {sd, rdWord.raw[30:0]};
      assign sstatusWord = {sd, rdWord.raw[30:0] & csrPkg::sstatusMask[30:0]};
    end
  endgenerate

  // the access decoder hits one address per cycle
  aOneView: assert property (@(posedge clk) disable iff (reset)
    !(writeMstatus && writeSstatus))
    else $error("mstatus and sstatus written in the same cycle");

  // privMode lets a trap win over any return
  aTrapAlone: assert property (@(posedge clk) disable iff (reset)
    !(trapTake && (retM || retS)))
    else $error("trap and return stacked in the same cycle");

endmodule

//--- src/csrUnit.sv
/*
  CSR unit top
  machine status, privilege mode and CSR access blocks
*/
`timescale 1ns/1ps
`include "csrDefaults.svh"

module csrUnit #(
  parameter int XLEN        = `CSR_XLEN,
  parameter int SUPPORTED_S = `CSR_SUPPORTED_S,
  parameter int SUPPORTED_U = `CSR_SUPPORTED_U,
  parameter int SUPPORTED_F = `CSR_SUPPORTED_F
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,
  input  logic               csrEn,
  input  privPkg::csrOp_t    csrOp,
  input  logic [11:0]        csrAddr,
  input  logic [XLEN-1:0]    csrSrc,
  input  logic               trap,
  input  logic               trapDelegated,
  input  logic               mret,
  input  logic               sret,
  input  logic               wfi,
  input  logic               fpWrite,
  output logic [XLEN-1:0]    readData,
  output privPkg::privMode_t privMode,
  output logic               illegal,
  output logic               statusMie,
  output logic               statusSie,
  output logic               statusTvm,
  output logic               statusMxr,
  output logic               statusSum,
  output logic               statusMprv,
  output privPkg::privMode_t statusMpp
);

  logic               writeMstatus;
  logic               writeSstatus;
  logic [XLEN-1:0]    csrWriteVal;
  logic [XLEN-1:0]    mstatusWord;
  logic [XLEN-1:0]    sstatusWord;
  logic               accessIllegal;
  logic               trapTake;
  logic               retM;
  logic               retS;
  logic               statusTsr;
  logic               statusTw;
  logic               statusSpp;
  privPkg::privMode_t trapTarget;
  privPkg::privMode_t fromMode;

  csrAccess #(.XLEN(XLEN), .SUPPORTED_S(SUPPORTED_S)) csrAccess_i (
    .clk(clk), .reset(reset), .stall(stall),
    .csrEn(csrEn), .csrOp(csrOp), .csrAddr(csrAddr), .csrSrc(csrSrc),
    .curMode(privMode),
    .mstatusWord(mstatusWord), .sstatusWord(sstatusWord),
    .writeMstatus(writeMstatus), .writeSstatus(writeSstatus),
    .csrWriteVal(csrWriteVal), .readData(readData),
    .accessIllegal(accessIllegal)
  );

  // MPIE / SPIE are visible through mstatus only
  csrStatus #(
    .XLEN(XLEN), .SUPPORTED_S(SUPPORTED_S),
    .SUPPORTED_U(SUPPORTED_U), .SUPPORTED_F(SUPPORTED_F)
  ) csrStatus_i (
    .clk(clk), .reset(reset), .stall(stall),
    .writeMstatus(writeMstatus), .writeSstatus(writeSstatus),
    .csrWriteVal(csrWriteVal),
    .trapTake(trapTake), .trapTarget(trapTarget), .fromMode(fromMode),
    .retM(retM), .retS(retS), .fpWrite(fpWrite),
    .mstatusWord(mstatusWord), .sstatusWord(sstatusWord),
    .statusMpp(statusMpp), .statusSpp(statusSpp),
    .statusMpie(), .statusSpie(),
    .statusMie(statusMie), .statusSie(statusSie),
    .statusTsr(statusTsr), .statusTw(statusTw), .statusTvm(statusTvm),
    .statusMxr(statusMxr), .statusSum(statusSum), .statusMprv(statusMprv)
  );

  privMode #(.SUPPORTED_S(SUPPORTED_S), .SUPPORTED_U(SUPPORTED_U)) privMode_i (
    .clk(clk), .reset(reset), .stall(stall),
    .trap(trap), .trapDelegated(trapDelegated),
    .mret(mret), .sret(sret), .wfi(wfi),
    .accessIllegal(accessIllegal),
    .statusTsr(statusTsr), .statusTw(statusTw),
    .statusMpp(statusMpp), .statusSpp(statusSpp),
    .curMode(privMode), .fromMode(fromMode),
    .trapTake(trapTake), .trapTarget(trapTarget),
    .retM(retM), .retS(retS), .illegal(illegal)
  );

endmodule

//--- src/privMode.sv
/*
  privilege mode
  current-mode register, trap target, return and wfi legality
*/
`timescale 1ns/1ps

module privMode #(
  parameter int SUPPORTED_S = 1,
  parameter int SUPPORTED_U = 1
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,
  input  logic               trap,
  input  logic               trapDelegated,
  input  logic               mret,
  input  logic               sret,
  input  logic               wfi,
  input  logic               accessIllegal,
  input  logic               statusTsr,
  input  logic               statusTw,
  input  privPkg::privMode_t statusMpp,
  input  logic               statusSpp,
  output privPkg::privMode_t curMode,
  output privPkg::privMode_t fromMode,
  output logic               trapTake,
  output privPkg::privMode_t trapTarget,
  output logic               retM,
  output logic               retS,
  output logic               illegal
);

  localparam logic hasS = SUPPORTED_S != 0;
  localparam logic hasU = SUPPORTED_U != 0;

  privPkg::privMode_t modeReg;
  privPkg::privMode_t sretMode;
  logic               inMachine;
  logic               mretOk;
  logic               sretOk;
  logic               wfiBad;

  assign curMode   = modeReg;
  assign fromMode  = modeReg;  // mode the trap leaves, goes to MPP / SPP
  assign inMachine = modeReg == privPkg::machineMode;

  // delegation only moves traps taken below machine
  assign trapTake   = trap;
  assign trapTarget = (trapDelegated && hasS && !inMachine) ? privPkg::superMode
                                                            : privPkg::machineMode;

  //////////////////////////////////////////////////
  // legality
  assign mretOk = inMachine;
  assign sretOk = hasS & (inMachine | (modeReg == privPkg::superMode & ~statusTsr));
  assign wfiBad = wfi & ~inMachine & statusTw;

  assign retM = mret & mretOk & ~trap;  // trap wins
  assign retS = sret & sretOk & ~trap;

  assign illegal = accessIllegal | (mret & ~mretOk) | (sret & ~sretOk) | wfiBad;

  // SPP only tells supervisor from user
  assign sretMode = statusSpp ? privPkg::superMode
                              : (hasU ? privPkg::userMode : privPkg::superMode);

  always_ff @(posedge clk) begin
    if (reset) begin
      modeReg <= privPkg::machineMode;
    end else if (~stall) begin
      if (trapTake)  modeReg <= trapTarget;
      else if (retM) modeReg <= statusMpp;
      else if (retS) modeReg <= sretMode;
    end
  end

  // MPP legalization upstream keeps the mode inside the build
  aModeBuilt: assert property (@(posedge clk) disable iff (reset)
    (modeReg == privPkg::machineMode) ||
    (modeReg == privPkg::superMode && hasS) ||
    (modeReg == privPkg::userMode && hasU))
    else $error("current mode not present in this build");

endmodule

//--- src/privPkg.sv
/*
  privilege package
  privilege-mode encodings and CSR operation codes
*/
package privPkg;

  // privilege levels as held in the mode register and in MPP
  typedef enum logic [1:0] {
    userMode    = 2'b00,
    superMode   = 2'b01,
    machineMode = 2'b11   // 10 is reserved
  } privMode_t;

  // low two bits of funct3 for csrrw / csrrs / csrrc
  typedef enum logic [1:0] {
    opWrite = 2'b01,
    opSet   = 2'b10,
    opClear = 2'b11
  } csrOp_t;

endpackage
